// File: source/mm_pkg.sv
// Sizes are fixed here for the whole engine; ADDR_W and IDX_W must track ROWS and DEPTH by hand
package mm_pkg;

  // Array geometry
  localparam int unsigned ROWS   = 4;  // Parallel rows W
  localparam int unsigned DEPTH  = 4;  // MAC stages per row H

  // Datapath widths
  localparam int unsigned DATA_W = 16; // Signed operand
  localparam int unsigned ACC_W  = 32; // Wrapping accumulator

  // Command address covers ROWS*DEPTH x entries
  localparam int unsigned ADDR_W = 4;
  localparam int unsigned IDX_W  = 2;  // Row index on result port

  // Opcodes on the command port
  typedef enum logic [2:0] {
    CMD_LD_X     = 3'd0, // x[row][col] at addr row*DEPTH+col
    CMD_LD_W     = 3'd1, // w[k] at addr k
    CMD_LD_Y     = 3'd2, // Bias of row addr, low half sign-extended
    CMD_RUN_BIAS = 3'd3, // Start from biases
    CMD_RUN_ACC  = 3'd4  // Start from previous results
  } cmd_e;

  // Four-phase port controller states
  typedef enum logic [1:0] {
    HS_IDLE     = 2'd0, // Waiting for work
    HS_BUSY     = 2'd1, // Executing or preparing data
    HS_ACK      = 2'd2, // Handshake line high
    HS_WAIT_LOW = 2'd3  // Waiting for a line to fall
  } hs_state_e;

endpackage

// File: source/mm_loader.sv
// One command in flight; runs are acked once drained, invalid opcodes acked without effect
`timescale 1ns/1ps

module mm_loader import mm_pkg::*; (
  input  logic                                    clk_i,
  input  logic                                    arst_n_i,
  // Command port, four-phase
  input  logic                                    cmd_req_i,
  input  cmd_e                                    cmd_op_i,
  input  logic [ADDR_W-1:0]                       cmd_addr_i,
  input  logic [ACC_W-1:0]                        cmd_data_i,
  output logic                                    cmd_ack_o,
  // Drain side
  input  logic                                    drain_busy_i,
  input  logic [ROWS-1:0][ACC_W-1:0]              feedback_i,
  // Run issue towards the rows
  output logic                                    run_valid_o,
  output logic [ROWS-1:0][DEPTH-1:0][DATA_W-1:0]  x_o,
  output logic [DEPTH-1:0][DATA_W-1:0]            w_o,
  output logic [ROWS-1:0][ACC_W-1:0]              start_o
);

  hs_state_e state_q;
  logic      run_valid_q;
  logic      seen_busy_q; // Drain went busy for this run

  // Operand storage
  logic [ROWS-1:0][DEPTH-1:0][DATA_W-1:0] x_q;
  logic [DEPTH-1:0][DATA_W-1:0]           w_q;
  logic [ROWS-1:0][ACC_W-1:0]             bias_q;
  logic [ROWS-1:0][ACC_W-1:0]             start_q;

  logic is_run;
  logic do_load;
  logic do_run;
  logic [IDX_W-1:0]        row_sel;
  logic [ADDR_W-IDX_W-1:0] col_sel;

  assign is_run  = (cmd_op_i == CMD_RUN_BIAS) || (cmd_op_i == CMD_RUN_ACC);
  assign do_load = (state_q == HS_BUSY) && !is_run;
  assign do_run  = (state_q == HS_BUSY) && is_run && !drain_busy_i; // Hold while draining

  // Address split for x writes
  assign row_sel = cmd_addr_i[ADDR_W-1 -: IDX_W];
  assign col_sel = cmd_addr_i[ADDR_W-IDX_W-1:0];

  // Command port FSM
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q     <= HS_IDLE;
      run_valid_q <= 1'b0;
      seen_busy_q <= 1'b0;
    end else begin
      run_valid_q <= do_run; // Single-cycle pulse
      case (state_q)
        HS_IDLE: begin
          if (cmd_req_i) state_q <= HS_BUSY;
        end
        HS_BUSY: begin
          if (do_load) state_q <= HS_ACK;        // Write lands this edge
          else if (do_run) state_q <= HS_WAIT_LOW;
        end
        HS_WAIT_LOW: begin
          // Wait for busy to rise, then fall
          if (drain_busy_i) seen_busy_q <= 1'b1;
          if (seen_busy_q && !drain_busy_i) begin
            seen_busy_q <= 1'b0;
            state_q     <= HS_ACK;
          end
        end
        HS_ACK: begin
          if (!cmd_req_i) state_q <= HS_IDLE; // Ack drops with req
        end
        default: state_q <= HS_IDLE;
      endcase
    end
  end

  // Operand writes
  always_ff @(posedge clk_i) begin
    if (do_load) begin
      case (cmd_op_i)
        CMD_LD_X: x_q[row_sel][col_sel] <= cmd_data_i[DATA_W-1:0];
        CMD_LD_W: w_q[col_sel] <= cmd_data_i[DATA_W-1:0];
        CMD_LD_Y: begin
          // Sign extend low half
          bias_q[cmd_addr_i[IDX_W-1:0]] <= {{(ACC_W-DATA_W){cmd_data_i[DATA_W-1]}},
                                             cmd_data_i[DATA_W-1:0]};
        end
        default: ;
      endcase
    end
  end

  // Start value snapshot at issue
  always_ff @(posedge clk_i) begin
    if (do_run) begin
      if (cmd_op_i == CMD_RUN_ACC) start_q <= feedback_i; // Continue previous dot product
      else start_q <= bias_q;
    end
  end

  assign cmd_ack_o   = (state_q == HS_ACK);
  assign run_valid_o = run_valid_q;
  assign x_o         = x_q;
  assign w_o         = w_q;
  assign start_o     = start_q;

  // Issue only into an idle drain
  a_run_not_busy: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) run_valid_o |-> !drain_busy_i
  );

  // Four-phase rule
  a_ack_needs_req: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) $rose(cmd_ack_o) |-> cmd_req_i
  );

endmodule

// File: source/mm_row.sv
// Fixed latency of DEPTH cycles, no stall; products and sums wrap at ACC_W bits
`timescale 1ns/1ps

module mm_row import mm_pkg::*; (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  logic                          valid_i,
  input  logic [DEPTH-1:0][DATA_W-1:0]  x_i,
  input  logic [DEPTH-1:0][DATA_W-1:0]  w_i,
  input  logic [ACC_W-1:0]              start_i,
  output logic                          valid_o,
  output logic [ACC_W-1:0]              sum_o
);

  logic [DEPTH-1:0] valid_q;  // One valid per stage
  logic [DEPTH-1:0] stage_v;  // Input valid of each stage

  // Partial sums, entry 0 is the start value
  logic signed [ACC_W-1:0] acc_c [DEPTH+1];

  // Operands travelling with the data
  logic [DEPTH-1:0][DATA_W-1:0] x_c [DEPTH];
  logic [DEPTH-1:0][DATA_W-1:0] w_c [DEPTH];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) valid_q <= '0;
    else valid_q <= {valid_q[DEPTH-2:0], valid_i}; // Valid shifts alongside data
  end

  assign stage_v  = {valid_q[DEPTH-2:0], valid_i};
  assign acc_c[0] = start_i;
  assign x_c[0]   = x_i;
  assign w_c[0]   = w_i;

  for (genvar k = 0; k < DEPTH; k++) begin : gen_stage
    logic signed [ACC_W-1:0] prod;

    // Full-width signed product
    assign prod = $signed(x_c[k][k]) * $signed(w_c[k][k]);

    always_ff @(posedge clk_i) begin
      if (stage_v[k]) acc_c[k+1] <= acc_c[k] + prod; // Wraps mod 2^ACC_W
    end

    // Last stage needs no operands downstream
    if (k < DEPTH-1) begin : gen_fwd
      always_ff @(posedge clk_i) begin
        if (stage_v[k]) begin
          x_c[k+1] <= x_c[k];
          w_c[k+1] <= w_c[k];
        end
      end
    end
  end

  assign valid_o = valid_q[DEPTH-1];
  assign sum_o   = acc_c[DEPTH];

  // End-to-end latency
  a_latency: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) valid_o == $past(valid_i, DEPTH)
  );

endmodule

// File: source/mm_drain.sv
// Expects all rows in lockstep and no new capture before the previous drain ends
`timescale 1ns/1ps

module mm_drain import mm_pkg::*; (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  logic [ROWS-1:0]             valid_i,
  input  logic [ROWS-1:0][ACC_W-1:0]  sum_i,
  // Result port, four-phase
  output logic                        res_req_o,
  output logic [IDX_W-1:0]            res_idx_o,
  output logic [ACC_W-1:0]            res_data_o,
  input  logic                        res_ack_i,
  // Back to the loader
  output logic                        busy_o,
  output logic [ROWS-1:0][ACC_W-1:0]  feedback_o
);

  hs_state_e                  state_q;
  logic [IDX_W-1:0]           idx_q;  // Row being sent
  logic [ROWS-1:0][ACC_W-1:0] res_q;  // Last results, also feedback
  logic                       capture;

  // Rows in lockstep so one bit decides
  assign capture = valid_i[0] && (state_q == HS_IDLE);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= HS_IDLE;
      idx_q   <= '0;
      res_q   <= '0; // Zero feedback after reset
    end else begin
      case (state_q)
        HS_IDLE: begin
          if (capture) begin
            res_q   <= sum_i;
            idx_q   <= '0;
            state_q <= HS_BUSY;
          end
        end
        HS_BUSY: state_q <= HS_ACK; // Req one cycle after capture
        HS_ACK: begin
          if (res_ack_i) state_q <= HS_WAIT_LOW; // Drop req
        end
        HS_WAIT_LOW: begin
          if (!res_ack_i) begin
            if (idx_q == IDX_W'(ROWS-1)) begin
              state_q <= HS_IDLE; // Last row done
            end else begin
              idx_q   <= idx_q + 1'b1;
              state_q <= HS_ACK;
            end
          end
        end
        default: state_q <= HS_IDLE;
      endcase
    end
  end

  assign res_req_o  = (state_q == HS_ACK);
  assign res_idx_o  = idx_q;
  assign res_data_o = res_q[idx_q];
  assign busy_o     = (state_q != HS_IDLE); // Capture through last ack low
  assign feedback_o = res_q;

  // Rows must finish together
  a_rows_agree: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) (valid_i == '0) || (&valid_i)
  );

  // Payload held during request
  a_data_stable: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    res_req_o && $past(res_req_o) |-> $stable(res_data_o) && $stable(res_idx_o)
  );

endmodule

// File: source/mm_engine.sv
// Top level; one run at a time, commands and results both over four-phase req/ack
`timescale 1ns/1ps

module mm_engine import mm_pkg::*; (
  input  logic               clk_i,
  input  logic               arst_n_i,
  // Command port
  input  logic               cmd_req_i,
  input  cmd_e               cmd_op_i,
  input  logic [ADDR_W-1:0]  cmd_addr_i,
  input  logic [ACC_W-1:0]   cmd_data_i,
  output logic               cmd_ack_o,
  // Result port
  output logic               res_req_o,
  output logic [IDX_W-1:0]   res_idx_o,
  output logic [ACC_W-1:0]   res_data_o,
  input  logic               res_ack_i
);

  logic                                   run_valid;
  logic [ROWS-1:0][DEPTH-1:0][DATA_W-1:0] x_row;     // x per row
  logic [DEPTH-1:0][DATA_W-1:0]           w_vec;     // Shared by all rows
  logic [ROWS-1:0][ACC_W-1:0]             start_val; // Bias or feedback
  logic [ROWS-1:0]                        row_valid;
  logic [ROWS-1:0][ACC_W-1:0]             row_sum;
  logic [ROWS-1:0][ACC_W-1:0]             feedback;
  logic                                   drain_busy;

  mm_loader u_loader (
    .clk_i        ( clk_i      ),
    .arst_n_i     ( arst_n_i   ),
    .cmd_req_i    ( cmd_req_i  ),
    .cmd_op_i     ( cmd_op_i   ),
    .cmd_addr_i   ( cmd_addr_i ),
    .cmd_data_i   ( cmd_data_i ),
    .cmd_ack_o    ( cmd_ack_o  ),
    .drain_busy_i ( drain_busy ),
    .feedback_i   ( feedback   ),
    .run_valid_o  ( run_valid  ),
    .x_o          ( x_row      ),
    .w_o          ( w_vec      ),
    .start_o      ( start_val  )
  );

  // W identical MAC chains
  for (genvar r = 0; r < ROWS; r++) begin : gen_rows
    mm_row u_row (
      .clk_i    ( clk_i         ),
      .arst_n_i ( arst_n_i      ),
      .valid_i  ( run_valid     ),
      .x_i      ( x_row[r]      ),
      .w_i      ( w_vec         ),
      .start_i  ( start_val[r]  ),
      .valid_o  ( row_valid[r]  ),
      .sum_o    ( row_sum[r]    )
    );
  end

  mm_drain u_drain (
    .clk_i      ( clk_i      ),
    .arst_n_i   ( arst_n_i   ),
    .valid_i    ( row_valid  ),
    .sum_i      ( row_sum    ),
    .res_req_o  ( res_req_o  ),
    .res_idx_o  ( res_idx_o  ),
    .res_data_o ( res_data_o ),
    .res_ack_i  ( res_ack_i  ),
    .busy_o     ( drain_busy ),
    .feedback_o ( feedback   )
  );

endmodule

// File: test/tb_mm_engine.sv
// Model uses mm_pkg sizes; results acked after 0..15 cycle delays, run stops after 4000 cycles
`timescale 1ns/1ps

module tb_mm_engine import mm_pkg::*; ();

  localparam int unsigned TIMEOUT_CYC = 4000; // Whole sequence needs under 2000

  logic              clk_i      = 1'b0;
  logic              arst_n_i   = 1'b0;
  logic              cmd_req_i  = 1'b0;
  cmd_e              cmd_op_i   = CMD_LD_X;
  logic [ADDR_W-1:0] cmd_addr_i = '0;
  logic [ACC_W-1:0]  cmd_data_i = '0;
  logic              cmd_ack_o;
  logic              res_req_o;
  logic [IDX_W-1:0]  res_idx_o;
  logic [ACC_W-1:0]  res_data_o;
  logic              res_ack_i  = 1'b0;

  // Reference model state
  logic signed [DATA_W-1:0] mx [ROWS][DEPTH];
  logic signed [DATA_W-1:0] mw [DEPTH];
  logic [ACC_W-1:0]         mbias [ROWS];
  logic [ACC_W-1:0]         mprev [ROWS]; // Last delivered results
  logic [ACC_W-1:0]         exp_q [ROWS]; // Expected for current run

  logic [31:0] lfsr_q = 32'hcbca_9300;
  int          ack_bits    = 3;    // Delay range of the result responder
  int          rows_done   = 0;    // Results fully handshaken this run
  logic        run_pending = 1'b0;
  int          err_cnt     = 0;
  int          res_cnt     = 0;
  int          test_cnt    = 0;
  int          fail_tests  = 0;
  int          cyc_cnt     = 0;

  always #50 clk_i = ~clk_i; // 100 ns period

  mm_engine uut (
    .clk_i      ( clk_i      ),
    .arst_n_i   ( arst_n_i   ),
    .cmd_req_i  ( cmd_req_i  ),
    .cmd_op_i   ( cmd_op_i   ),
    .cmd_addr_i ( cmd_addr_i ),
    .cmd_data_i ( cmd_data_i ),
    .cmd_ack_o  ( cmd_ack_o  ),
    .res_req_o  ( res_req_o  ),
    .res_idx_o  ( res_idx_o  ),
    .res_data_o ( res_data_o ),
    .res_ack_i  ( res_ack_i  )
  );

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
      v      = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // Signed dot product of one row, wrapping at 32 bits
  function automatic logic [ACC_W-1:0] dot_row(input int r);
    logic signed [ACC_W-1:0] acc;
    logic signed [ACC_W-1:0] p;
    acc = '0;
    for (int k = 0; k < DEPTH; k++) begin
      p   = mx[r][k] * mw[k]; // Operands sign-extend to 32 bits
      acc = acc + p;
    end
    return acc;
  endfunction

  // One four-phase command, returns once ack is low again
  task automatic send_cmd(input cmd_e op, input logic [ADDR_W-1:0] addr,
                          input logic [ACC_W-1:0] data);
    @(posedge clk_i);
    cmd_op_i   <= op;
    cmd_addr_i <= addr;
    cmd_data_i <= data;
    cmd_req_i  <= 1'b1;
    do @(negedge clk_i); while (!cmd_ack_o);
    @(posedge clk_i);
    cmd_req_i <= 1'b0;
    do @(negedge clk_i); while (cmd_ack_o);
  endtask

  task automatic put_x(input int r, input int k, input logic [DATA_W-1:0] v);
    mx[r][k] = v;
    send_cmd(CMD_LD_X, ADDR_W'(r * DEPTH + k), {{(ACC_W-DATA_W){1'b0}}, v});
  endtask

  task automatic put_w(input int k, input logic [DATA_W-1:0] v);
    mw[k] = v;
    send_cmd(CMD_LD_W, ADDR_W'(k), {{(ACC_W-DATA_W){1'b0}}, v});
  endtask

  // Upper half of d must be ignored
  task automatic put_bias(input int r, input logic [ACC_W-1:0] d);
    mbias[r] = {{(ACC_W-DATA_W){d[DATA_W-1]}}, d[DATA_W-1:0]};
    send_cmd(CMD_LD_Y, ADDR_W'(r), d);
  endtask

  task automatic load_random(input bit with_bias);
    for (int r = 0; r < ROWS; r++) begin
      for (int k = 0; k < DEPTH; k++) put_x(r, k, DATA_W'(rand_bits(DATA_W)));
    end
    for (int k = 0; k < DEPTH; k++) put_w(k, DATA_W'(rand_bits(DATA_W)));
    if (with_bias) begin
      for (int r = 0; r < ROWS; r++) put_bias(r, rand_bits(ACC_W));
    end
  endtask

  // Expected sums fixed before issue, the assertions compare on delivery
  task automatic do_run(input cmd_e op);
    for (int r = 0; r < ROWS; r++) begin
      exp_q[r] = ((op == CMD_RUN_ACC) ? mprev[r] : mbias[r]) + dot_row(r);
    end
    rows_done   = 0;
    run_pending = 1'b1;
    send_cmd(op, '0, '0); // Ack means all rows drained
    run_pending = 1'b0;
    for (int r = 0; r < ROWS; r++) mprev[r] = exp_q[r];
  endtask

  task automatic report(input string name, input int errs_before);
    test_cnt++;
    if (err_cnt == errs_before) begin
      $display("Test %0d %s: ok", test_cnt, name);
    end else begin
      $display("Test %0d %s: %0d errors", test_cnt, name, err_cnt - errs_before);
      fail_tests++;
    end
  endtask

  // Result side master, random ack delay per row
  initial begin : result_responder
    int unsigned dly;
    forever begin
      @(negedge clk_i);
      if (res_req_o) begin
        dly = rand_bits(ack_bits);
        repeat (dly) @(posedge clk_i);
        @(posedge clk_i);
        res_ack_i <= 1'b1;
        do @(negedge clk_i); while (res_req_o);
        @(posedge clk_i);
        res_ack_i <= 1'b0;
        res_cnt++;
        rows_done++; // Also the next expected row index
      end
    end
  end

  always @(posedge clk_i) begin
    cyc_cnt <= cyc_cnt + 1;
    if (cyc_cnt >= TIMEOUT_CYC) begin
      $display("Timeout: sequence still running after %0d cycles", TIMEOUT_CYC);
      $display("Result: FAILED");
      $finish;
    end
  end

  result_value: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) $rose(res_req_o) |-> res_data_o == exp_q[res_idx_o]
  ) else begin
    $display("FAIL res_data_o row %h: got %h expected %h", res_idx_o, res_data_o,
             exp_q[res_idx_o]);
    err_cnt++;
  end

  // Rows leave in order 0 to ROWS-1
  result_order: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) $rose(res_req_o) |-> int'(res_idx_o) == rows_done
  ) else begin
    $display("FAIL res_idx_o: got %h expected %h", res_idx_o, rows_done);
    err_cnt++;
  end

  result_stable: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    res_req_o && $past(res_req_o) |-> $stable(res_data_o) && $stable(res_idx_o)
  ) else begin
    $display("Result payload changed while res_req_o was high, now row %h data %h",
             res_idx_o, res_data_o);
    err_cnt++;
  end

  run_ack_after_drain: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) $rose(cmd_ack_o) && run_pending |-> rows_done == ROWS
  ) else begin
    $display("Run acknowledged after only %0d of %0d results", rows_done, ROWS);
    err_cnt++;
  end

  reset_outputs: assert property (
    @(posedge clk_i) $rose(arst_n_i) |-> !cmd_ack_o && !res_req_o
  ) else begin
    $display("Handshake outputs not low right after reset");
    err_cnt++;
  end

  initial begin : main_seq
    int errs;
    for (int r = 0; r < ROWS; r++) mprev[r] = '0; // Feedback is zero after reset
    repeat (2) @(posedge clk_i);
    arst_n_i <= 1'b1;

    // Accumulate before any run must start from zero
    errs = err_cnt;
    load_random(1'b0);
    do_run(CMD_RUN_ACC);
    report("reset state", errs);

    errs = err_cnt;
    load_random(1'b1);
    do_run(CMD_RUN_BIAS);
    report("bias run", errs);

    // Fresh biases too, which the run must ignore
    errs = err_cnt;
    load_random(1'b1);
    do_run(CMD_RUN_ACC);
    report("accumulate", errs);

    errs = err_cnt;
    ack_bits = 4; // Longer back-pressure
    for (int i = 0; i < 3; i++) begin
      load_random(1'b1);
      do_run((i == 1) ? CMD_RUN_ACC : CMD_RUN_BIAS);
    end
    ack_bits = 3;
    report("handshake", errs);

    // Extreme operands, the first run leaves starts near the 32-bit limit
    errs = err_cnt;
    for (int r = 0; r < ROWS; r++) begin
      for (int k = 0; k < DEPTH; k++) begin
        put_x(r, k, (r == 0 || (r == 2 && k % 2 == 0) || (r == 3 && k < 3)) ?
                    16'h8000 : 16'h7fff);
      end
      put_bias(r, (r == 1) ? 32'hffff_8000 : 32'h1234_7fff);
    end
    for (int k = 0; k < DEPTH; k++) put_w(k, 16'h8000);
    do_run(CMD_RUN_BIAS);
    do_run(CMD_RUN_ACC);
    report("wrap and sign", errs);

    $display("Summary: %0d tests, %0d failed, %0d results checked, %0d errors",
             test_cnt, fail_tests, res_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// File: mm_engine.f
source/mm_pkg.sv
source/mm_loader.sv
source/mm_row.sv
source/mm_drain.sv
source/mm_engine.sv
test/tb_mm_engine.sv

// File: run_sim.sh
#!/bin/sh
# Builds tb_mm_engine with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f mm_engine.f --top-module tb_mm_engine -o tb_mm_engine \
  && ./obj_dir/tb_mm_engine | tee /dev/stderr | grep -q "Result: PASSED" \
  && echo "Simulation finished without errors" \
  || { echo "Simulation reported errors or did not build"; exit 1; }
